/* design/adc_pkg.sv */
// shared widths, sample record and state types for the serial adc front end, imported by the rtl
package adc_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------

  // adc conversion word
  localparam int SAMPLE_BITS = 16;
  // sample sequence number, also used for the overrun counter
  localparam int SEQ_BITS = 8;
  // capture bit counter, must hold 0..SAMPLE_BITS
  localparam int FRAME_CNT_BITS = $clog2(SAMPLE_BITS + 1);

  // ----------------------------------------------------------
  // error codes carried in every sample
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    // clean frame, full word
    err_none        = 2'd0,
    // adc never raised busy within the timeout
    err_no_busy     = 2'd1,
    // busy dropped before a full word was shifted in
    err_short_frame = 2'd2
  } adc_err_t;

  // sample record, data in the top bits
  typedef struct packed {
    logic [SAMPLE_BITS-1:0] data;
    logic [SEQ_BITS-1:0]    seq;
    adc_err_t               err;
  } adc_sample_t;

  // ----------------------------------------------------------
  // sequencer states
  // ----------------------------------------------------------

  typedef enum logic [2:0] {
    st_idle,
    st_conv,
    st_wait_busy,
    st_shift,
    st_done
  } seq_state_t;

endpackage

/* design/conv_timer.sv */
// periodic conversion-start generator, strobes tick every cfg_period cycles while enabled
`timescale 1ns/1ps

module conv_timer #(
  parameter int PERIOD_BITS = 16
) (
  input  logic                   clk33,
  input  logic                   reset,
  input  logic                   enable,
  input  logic [PERIOD_BITS-1:0] cfg_period,
  output logic                   tick
);

  // ----------------------------------------------------------
  // down-counter
  // ----------------------------------------------------------

  // cycles left until the next strobe
  logic [PERIOD_BITS-1:0] count;
  // end of period, a period of 0 behaves like 1
  logic                   expire;

  assign expire = (count <= PERIOD_BITS'(1));

  // reload from cfg_period each period
  // so a new period takes effect at the next reload
  always_ff @(posedge clk33) begin
    if (reset) begin
      count <= cfg_period;
      tick  <= 1'b0;
    end else if (!enable) begin
      // held loaded, count restarts cleanly on enable rise
      count <= cfg_period;
      tick  <= 1'b0;
    end else if (expire) begin
      count <= cfg_period;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // notes
  // ----------------------------------------------------------

  // enable rising with count = P gives the first tick
  // P cycles later, then one tick every P cycles
  // tick is registered, one cycle wide

endmodule

/* design/serial_capture.sv */
// serial word capture from the adc: syncs busy/sclk/sdout, shifts bits msb first, flags frame end
`timescale 1ns/1ps

module serial_capture
  import adc_pkg::*;
(
  input  logic                      clk33,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      adc_busy,
  input  logic                      adc_sclk,
  input  logic                      adc_sdout,
  output logic                      busy_seen,
  output logic                      frame_done,
  output logic [SAMPLE_BITS-1:0]    frame_data,
  output logic [FRAME_CNT_BITS-1:0] frame_bits
);

  // bit positions in the sync vector
  localparam int BUSY_IDX  = 2;
  localparam int SCLK_IDX  = 1;
  localparam int SDOUT_IDX = 0;

  // first and second sync stage
  logic [2:0]                sync_meta;
  logic [2:0]                sync_q;
  // synchronized adc lines
  logic                      busy_s;
  logic                      sclk_s;
  logic                      sdout_s;
  // one cycle delayed copies for edge detect
  logic                      busy_d;
  logic                      sclk_d;
  logic                      sclk_rise;
  logic                      busy_fall;
  // word not yet complete
  logic                      frame_open;
  logic                      take_bit;
  logic [SAMPLE_BITS-1:0]    shift_reg;
  logic [FRAME_CNT_BITS-1:0] bit_count;

  // ----------------------------------------------------------
  // two-flop synchronizers
  // ----------------------------------------------------------

  always_ff @(posedge clk33) begin
    if (reset) begin
      sync_meta <= '0;
      sync_q    <= '0;
    end else begin
      sync_meta <= {adc_busy, adc_sclk, adc_sdout};
      sync_q    <= sync_meta;
    end
  end

  assign busy_s  = sync_q[BUSY_IDX];
  assign sclk_s  = sync_q[SCLK_IDX];
  assign sdout_s = sync_q[SDOUT_IDX];

  // ----------------------------------------------------------
  // edge detect
  // ----------------------------------------------------------

  always_ff @(posedge clk33) begin
    if (reset) begin
      busy_d <= 1'b0;
      sclk_d <= 1'b0;
    end else begin
      busy_d <= busy_s;
      sclk_d <= sclk_s;
    end
  end

  assign sclk_rise = sclk_s & ~sclk_d;
  assign busy_fall = busy_d & ~busy_s;

  // ----------------------------------------------------------
  // shift register and bit count
  // ----------------------------------------------------------

  // stop taking bits once a full word is in
  assign frame_open = (bit_count < FRAME_CNT_BITS'(SAMPLE_BITS));
  assign take_bit   = sclk_rise & busy_s & frame_open;

  // msb first, sdout sampled with the same sync delay as sclk
  always_ff @(posedge clk33) begin
    if (clear) begin
      shift_reg <= '0;
    end else if (take_bit) begin
      shift_reg <= {shift_reg[SAMPLE_BITS-2:0], sdout_s};
    end
  end

  // saturates at SAMPLE_BITS
  always_ff @(posedge clk33) begin
    if (reset || clear) begin
      bit_count <= '0;
    end else if (take_bit) begin
      bit_count <= bit_count + 1'b1;
    end
  end

  // frame end on busy falling, data already stable
  always_ff @(posedge clk33) begin
    if (reset) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= busy_fall;
    end
  end

  assign busy_seen  = busy_s;
  assign frame_data = shift_reg;
  assign frame_bits = bit_count;

endmodule

/* design/adc_sequencer.sv */
// conversion sequencer: drives the convert line, times busy, classifies the frame, emits samples
`timescale 1ns/1ps

module adc_sequencer
  import adc_pkg::*;
#(
  parameter int CONV_LOW_CYCLES = 4,
  parameter int BUSY_TIMEOUT    = 64
) (
  input  logic                      clk33,
  input  logic                      reset,
  input  logic                      tick,
  input  logic                      trigger,
  input  logic                      busy_seen,
  input  logic                      frame_done,
  input  logic [SAMPLE_BITS-1:0]    frame_data,
  input  logic [FRAME_CNT_BITS-1:0] frame_bits,
  output logic                      adc_ncnv,
  output logic                      capture_clear,
  output adc_sample_t               sample,
  output logic                      sample_valid,
  output logic [SEQ_BITS-1:0]       overrun_count
);

  // one counter for both the low pulse and the busy timeout
  localparam int CNT_MAX  = (BUSY_TIMEOUT > CONV_LOW_CYCLES) ? BUSY_TIMEOUT : CONV_LOW_CYCLES;
  localparam int CNT_BITS = $clog2(CNT_MAX + 1);
  localparam logic [CNT_BITS-1:0] CONV_LAST = CNT_BITS'(CONV_LOW_CYCLES - 1);
  localparam logic [CNT_BITS-1:0] BUSY_LAST = CNT_BITS'(BUSY_TIMEOUT - 1);

  seq_state_t             state;
  logic [CNT_BITS-1:0]    cycle_cnt;
  // any start source
  logic                   start_req;
  // frame ended while we were listening
  logic                   frame_end;
  // no busy within BUSY_TIMEOUT cycles
  logic                   busy_timeout;
  logic                   frame_short;
  // record fields, latched at frame end or timeout
  logic [SAMPLE_BITS-1:0] data_word;
  adc_err_t               err_code;
  logic [SEQ_BITS-1:0]    seq_num;

  assign start_req    = tick | trigger;
  assign frame_end    = frame_done & ((state == st_shift) | (state == st_wait_busy));
  assign busy_timeout = (state == st_wait_busy) & ~frame_done & ~busy_seen &
                        (cycle_cnt == BUSY_LAST);
  assign frame_short  = (frame_bits < FRAME_CNT_BITS'(SAMPLE_BITS));

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk33) begin
    if (reset) begin
      state         <= st_idle;
      cycle_cnt     <= '0;
      adc_ncnv      <= 1'b1;
      capture_clear <= 1'b0;
    end else begin
      capture_clear <= 1'b0;
      case (state)
        st_idle: begin
          // ncnv drops on the next cycle, clear lands in st_conv
          if (start_req) begin
            state         <= st_conv;
            adc_ncnv      <= 1'b0;
            capture_clear <= 1'b1;
            cycle_cnt     <= '0;
          end
        end
        st_conv: begin
          // low for exactly CONV_LOW_CYCLES cycles
          if (cycle_cnt == CONV_LAST) begin
            adc_ncnv  <= 1'b1;
            cycle_cnt <= '0;
            state     <= st_wait_busy;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        st_wait_busy: begin
          // timeout counted from ncnv rise
          if (frame_end || busy_timeout) begin
            state <= st_done;
          end else if (busy_seen) begin
            state <= st_shift;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        st_shift: begin
          // capture does the work, wait for busy to fall
          if (frame_end) begin
            state <= st_done;
          end
        end
        st_done: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // frame classification
  // ----------------------------------------------------------

  always_ff @(posedge clk33) begin
    if (frame_end) begin
      data_word <= frame_data;
      err_code  <= frame_short ? err_short_frame : err_none;
    end else if (busy_timeout) begin
      data_word <= '0;
      err_code  <= err_no_busy;
    end
  end

  // ----------------------------------------------------------
  // sample output and counters
  // ----------------------------------------------------------

  // seq steps on every sample, error ones too
  always_ff @(posedge clk33) begin
    if (reset) begin
      sample_valid <= 1'b0;
      seq_num      <= '0;
    end else begin
      sample_valid <= (state == st_done);
      if (state == st_done) begin
        seq_num <= seq_num + 1'b1;
      end
    end
  end

  // record held until the next strobe
  always_ff @(posedge clk33) begin
    if (state == st_done) begin
      sample <= '{data: data_word, seq: seq_num, err: err_code};
    end
  end

  // starts outside st_idle are dropped, count saturates
  always_ff @(posedge clk33) begin
    if (reset) begin
      overrun_count <= '0;
    end else if (start_req && (state != st_idle) && (overrun_count != '1)) begin
      overrun_count <= overrun_count + 1'b1;
    end
  end

endmodule

/* design/adc_frontend_top.sv */
// top of the serial adc front end, connects the timer, sequencer and capture on clk33
`timescale 1ns/1ps

module adc_frontend_top
  import adc_pkg::*;
#(
  parameter int CONV_LOW_CYCLES = 4,
  parameter int BUSY_TIMEOUT    = 64,
  parameter int PERIOD_BITS     = 16
) (
  input  logic                   clk33,
  input  logic                   reset,
  input  logic                   enable,
  input  logic [PERIOD_BITS-1:0] cfg_period,
  input  logic                   trigger,
  input  logic                   adc_busy,
  input  logic                   adc_sclk,
  input  logic                   adc_sdout,
  output logic                   adc_ncnv,
  output adc_sample_t            sample,
  output logic                   sample_valid,
  output logic [SEQ_BITS-1:0]    overrun_count
);

  // ----------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------

  // periodic start
  logic                      tick;
  // capture reset at conversion start
  logic                      capture_clear;
  logic                      busy_seen;
  logic                      frame_done;
  logic [SAMPLE_BITS-1:0]    frame_data;
  logic [FRAME_CNT_BITS-1:0] frame_bits;

  // ----------------------------------------------------------
  // blocks
  // ----------------------------------------------------------

  conv_timer #(
    .PERIOD_BITS (PERIOD_BITS)
  ) conv_timer_i (
    .clk33      (clk33),
    .reset      (reset),
    .enable     (enable),
    .cfg_period (cfg_period),
    .tick       (tick)
  );

  adc_sequencer #(
    .CONV_LOW_CYCLES (CONV_LOW_CYCLES),
    .BUSY_TIMEOUT    (BUSY_TIMEOUT)
  ) adc_sequencer_i (
    .clk33         (clk33),
    .reset         (reset),
    .tick          (tick),
    .trigger       (trigger),
    .busy_seen     (busy_seen),
    .frame_done    (frame_done),
    .frame_data    (frame_data),
    .frame_bits    (frame_bits),
    .adc_ncnv      (adc_ncnv),
    .capture_clear (capture_clear),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .overrun_count (overrun_count)
  );

  // adc lines enter here, async to the design
  serial_capture serial_capture_i (
    .clk33      (clk33),
    .reset      (reset),
    .clear      (capture_clear),
    .adc_busy   (adc_busy),
    .adc_sclk   (adc_sclk),
    .adc_sdout  (adc_sdout),
    .busy_seen  (busy_seen),
    .frame_done (frame_done),
    .frame_data (frame_data),
    .frame_bits (frame_bits)
  );

endmodule

/* tb/adc_model.sv */
// behavioral serial adc that answers the convert line with busy, sclk and data in the testbench
`timescale 1ns/1ps

module adc_model
  import adc_pkg::*;
(
  input  logic                   clk33,
  input  logic                   reset,
  input  logic                   adc_ncnv,
  input  logic [SAMPLE_BITS-1:0] word,
  input  logic [1:0]             mode,
  input  logic [4:0]             bits_short,
  output logic                   adc_busy,
  output logic                   adc_sclk,
  output logic                   adc_sdout
);

  // fault mode coding matches the testbench table
  localparam logic [1:0] MODE_NO_BUSY = 2'd1;
  localparam logic [1:0] MODE_SHORT   = 2'd2;

  logic                   ncnv_d;
  // word latched at conversion start
  logic [SAMPLE_BITS-1:0] word_q;
  // bits to send in this frame
  int                     nbits;
  int                     sent;
  // sclk half period counter
  int                     div;

  // ----------------------------------------------------------
  // conversion and serial output
  // ----------------------------------------------------------

  // outputs change 1 ns after the clock edge
  initial begin
    adc_busy  = 1'b0;
    adc_sclk  = 1'b0;
    adc_sdout = 1'b0;
    ncnv_d    = 1'b1;
    word_q    = '0;
    nbits     = 0;
    sent      = 0;
    div       = 0;
    forever begin
      @(posedge clk33);
      #1;
      if (reset) begin
        adc_busy = 1'b0;
        adc_sclk = 1'b0;
        ncnv_d   = 1'b1;
      end else begin
        if (adc_busy) begin
          // sclk toggles every 2 cycles
          div = div + 1;
          if (div == 2) begin
            div = 0;
            if (!adc_sclk) begin
              adc_sclk = 1'b1;
              sent     = sent + 1;
            end else begin
              adc_sclk = 1'b0;
              // data changes on the falling edge
              // busy drops after the last bit
              if (sent >= nbits) begin
                adc_busy = 1'b0;
              end else begin
                adc_sdout = word_q[SAMPLE_BITS-1-sent];
              end
            end
          end
        end else if (adc_ncnv && !ncnv_d && (mode != MODE_NO_BUSY)) begin
          // ncnv rising starts the conversion
          word_q    = word;
          nbits     = (mode == MODE_SHORT) ? int'(bits_short) : SAMPLE_BITS;
          sent      = 0;
          div       = 0;
          adc_busy  = 1'b1;
          adc_sclk  = 1'b0;
          adc_sdout = word[SAMPLE_BITS-1];
        end
        ncnv_d = adc_ncnv;
      end
    end
  end

endmodule

/* tb/adc_frontend_tb.sv */
// testbench for the adc front end that runs a table of conversions in a loop against the adc model
`timescale 1ns/1ps

module adc_frontend_tb
  import adc_pkg::*;
();

  localparam int CONV_LOW_CYCLES = 4;
  localparam int BUSY_TIMEOUT    = 64;
  localparam int PERIOD_BITS     = 16;
  // shorter than one conversion so starts get dropped
  localparam logic [PERIOD_BITS-1:0] TIMER_PERIOD = 16'd20;
  localparam int NUM_ROWS    = 10;
  localparam int WAIT_CYCLES = 400;
  localparam logic [1:0] MODE_NORMAL  = 2'd0;
  localparam logic [1:0] MODE_NO_BUSY = 2'd1;
  localparam logic [1:0] MODE_SHORT   = 2'd2;

  // one table row holds stimulus then expected values
  typedef struct packed {
    logic [SAMPLE_BITS-1:0] word;
    logic [1:0]             mode;
    logic [4:0]             bits_short;
    logic                   use_timer;
    adc_err_t               exp_err;
    logic [SAMPLE_BITS-1:0] exp_data;
  } row_t;

  logic                   clk33;
  logic                   reset;
  logic                   enable;
  logic [PERIOD_BITS-1:0] cfg_period;
  logic                   trigger;
  logic                   adc_busy;
  logic                   adc_sclk;
  logic                   adc_sdout;
  logic                   adc_ncnv;
  adc_sample_t            sample;
  logic                   sample_valid;
  logic [SEQ_BITS-1:0]    overrun_count;
  logic [SAMPLE_BITS-1:0] model_word;
  logic [1:0]             model_mode;
  logic [4:0]             model_bits;

  row_t                   table_rows [NUM_ROWS];
  logic [SEQ_BITS-1:0]    exp_seq;
  int                     error_count = 0;
  int                     pass_count  = 0;
  int                     fail_count  = 0;
  int                     low_run     = 0;
  int                     pulse_count = 0;

  adc_frontend_top #(
    .CONV_LOW_CYCLES (CONV_LOW_CYCLES),
    .BUSY_TIMEOUT    (BUSY_TIMEOUT),
    .PERIOD_BITS     (PERIOD_BITS)
  ) adc_frontend_top_i (
    .clk33 (clk33), .reset (reset), .enable (enable), .cfg_period (cfg_period),
    .trigger (trigger), .adc_busy (adc_busy), .adc_sclk (adc_sclk),
    .adc_sdout (adc_sdout), .adc_ncnv (adc_ncnv), .sample (sample),
    .sample_valid (sample_valid), .overrun_count (overrun_count)
  );

  adc_model adc_model_i (
    .clk33 (clk33), .reset (reset), .adc_ncnv (adc_ncnv), .word (model_word),
    .mode (model_mode), .bits_short (model_bits), .adc_busy (adc_busy),
    .adc_sclk (adc_sclk), .adc_sdout (adc_sdout)
  );

  // 20 ns period
  always #10 clk33 = ~clk33;

  // ----------------------------------------------------------
  // convert pulse width counted at the falling edge
  // ----------------------------------------------------------

  always @(negedge clk33) begin
    if (reset) begin
      low_run = 0;
    end else if (!adc_ncnv) begin
      low_run = low_run + 1;
    end else if (low_run != 0) begin
      if (low_run != CONV_LOW_CYCLES) begin
        $display("CHECK FAILED adc_ncnv low cycles got %h expected %h", low_run, CONV_LOW_CYCLES);
        error_count++;
      end
      pulse_count++;
      low_run = 0;
    end
  end

  // ----------------------------------------------------------
  // table
  // ----------------------------------------------------------

  function automatic logic [SAMPLE_BITS-1:0] random_word();
    logic [31:0] rnd;
    rnd = $urandom();
    return rnd[SAMPLE_BITS-1:0];
  endfunction

  // expected record follows from the mode
  function automatic row_t make_row(input logic [SAMPLE_BITS-1:0] word, input logic [1:0] mode,
                                    input logic [4:0] bits, input logic use_timer);
    row_t r;
    r.word       = word;
    r.mode       = mode;
    r.bits_short = bits;
    r.use_timer  = use_timer;
    case (mode)
      MODE_NO_BUSY: begin
        r.exp_err  = err_no_busy;
        r.exp_data = '0;
      end
      MODE_SHORT: begin
        // first bits of the word land in the low end
        r.exp_err  = err_short_frame;
        r.exp_data = word >> (SAMPLE_BITS - int'(bits));
      end
      default: begin
        r.exp_err  = err_none;
        r.exp_data = word;
      end
    endcase
    return r;
  endfunction

  // timer rows go last and enable stays high from there on
  task automatic fill_table();
    table_rows[0] = make_row(16'hA5C3, MODE_NORMAL, 5'd0, 1'b0);
    table_rows[1] = make_row(random_word(), MODE_NORMAL, 5'd0, 1'b0);
    table_rows[2] = make_row(random_word(), MODE_NO_BUSY, 5'd0, 1'b0);
    table_rows[3] = make_row(16'h0001, MODE_NORMAL, 5'd0, 1'b0);
    table_rows[4] = make_row(random_word(), MODE_SHORT, 5'd5, 1'b0);
    table_rows[5] = make_row(random_word(), MODE_SHORT, 5'd11, 1'b0);
    table_rows[6] = make_row(16'hFFFF, MODE_NORMAL, 5'd0, 1'b0);
    table_rows[7] = make_row(random_word(), MODE_NORMAL, 5'd0, 1'b1);
    table_rows[8] = make_row(random_word(), MODE_NORMAL, 5'd0, 1'b1);
    table_rows[9] = make_row(random_word(), MODE_NORMAL, 5'd0, 1'b1);
  endtask

  // ----------------------------------------------------------
  // one conversion per row
  // ----------------------------------------------------------

  task automatic run_row(input int idx);
    row_t                r;
    int                  errs_before;
    int                  pulses_before;
    logic [SEQ_BITS-1:0] overruns_before;
    int                  waited;
    logic                got;
    r               = table_rows[idx];
    errs_before     = error_count;
    pulses_before   = pulse_count;
    overruns_before = overrun_count;
    @(posedge clk33);
    #1;
    model_word = r.word;
    model_mode = r.mode;
    model_bits = r.bits_short;
    if (r.use_timer) begin
      cfg_period = TIMER_PERIOD;
      enable     = 1'b1;
    end else begin
      trigger = 1'b1;
      @(posedge clk33);
      #1;
      trigger = 1'b0;
    end
    waited = 0;
    got    = 1'b0;
    while (!got && (waited < WAIT_CYCLES)) begin
      @(negedge clk33);
      waited++;
      got = sample_valid;
    end
    if (!got) begin
      $display("test %0d: no sample arrived within %0d cycles", idx, WAIT_CYCLES);
      error_count++;
    end else begin
      if (sample.data !== r.exp_data) begin
        $display("CHECK FAILED test %0d sample.data got %h expected %h", idx, sample.data,
                 r.exp_data);
        error_count++;
      end
      if (sample.err !== r.exp_err) begin
        $display("CHECK FAILED test %0d sample.err got %h expected %h", idx, sample.err,
                 r.exp_err);
        error_count++;
      end
      if (sample.seq !== exp_seq) begin
        $display("CHECK FAILED test %0d sample.seq got %h expected %h", idx, sample.seq, exp_seq);
        error_count++;
      end
      // a timer faster than one conversion drops starts during every timer row
      if (r.use_timer && (overrun_count == overruns_before)) begin
        $display("CHECK FAILED test %0d overrun_count got %h expected above %h", idx,
                 overrun_count, overruns_before);
        error_count++;
      end
      if (!r.use_timer && (overrun_count != '0)) begin
        $display("CHECK FAILED test %0d overrun_count got %h expected 00", idx, overrun_count);
        error_count++;
      end
      if (pulse_count - pulses_before != 1) begin
        $display("CHECK FAILED test %0d adc_ncnv pulses got %h expected 1", idx,
                 pulse_count - pulses_before);
        error_count++;
      end
      exp_seq++;
      // strobe is one cycle wide
      @(negedge clk33);
      if (sample_valid !== 1'b0) begin
        $display("CHECK FAILED test %0d sample_valid next cycle got %h expected 0", idx,
                 sample_valid);
        error_count++;
      end
    end
    if (error_count == errs_before) begin
      pass_count++;
      $display("test %0d mode %0d timer %0d word %h: ok", idx, r.mode, r.use_timer, r.word);
    end else begin
      fail_count++;
      $display("test %0d mode %0d timer %0d word %h: failed", idx, r.mode, r.use_timer, r.word);
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    clk33      = 1'b0;
    reset      = 1'b1;
    enable     = 1'b0;
    cfg_period = TIMER_PERIOD;
    trigger    = 1'b0;
    model_word = '0;
    model_mode = MODE_NORMAL;
    model_bits = 5'd0;
    exp_seq    = '0;
    void'($urandom(85));
    fill_table();
    repeat (3) @(posedge clk33);
    #1;
    reset = 1'b0;
    @(negedge clk33);
    // idle levels out of reset
    if (adc_ncnv !== 1'b1) begin
      $display("CHECK FAILED adc_ncnv after reset got %h expected 1", adc_ncnv);
      error_count++;
    end
    if (sample_valid !== 1'b0) begin
      $display("CHECK FAILED sample_valid after reset got %h expected 0", sample_valid);
      error_count++;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    @(posedge clk33);
    #1;
    enable = 1'b0;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", NUM_ROWS, pass_count,
             fail_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
design/adc_pkg.sv
design/conv_timer.sv
design/serial_capture.sv
design/adc_sequencer.sv
design/adc_frontend_top.sv
tb/adc_model.sv
tb/adc_frontend_tb.sv

/* Makefile */
TOP := adc_frontend_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with verilator and run it"
	@echo "make clean  remove the verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
